// ==== hdl/turfio_pkg.sv ====
package turfio_pkg;

    ////////////////////////////////////////
    // Wishbone widths and address split
    ////////////////////////////////////////

    // Word address and data word
    typedef logic [24:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // Address space at bits 24..22
    typedef logic [2:0]  space_t;
    // Module select at bits 21..10
    typedef logic [11:0] module_idx_t;
    // Register within a module at bits 9..0
    typedef logic [9:0]  reg_idx_t;

    // Overlay of the three fields on a word address
    typedef struct packed {
        space_t      space;
        module_idx_t mod;
        reg_idx_t    idx;
    } wb_addr_fields_t;

    // Space 0 is ours, the rest belongs to the SURFs
    localparam space_t      SPACE_TURFIO = 3'd0;
    // Id/control block lives at module 0
    localparam module_idx_t MOD_ID_CTRL  = 12'd0;

    // Id/control register map
    localparam reg_idx_t REG_IDENT       = 10'd0;
    localparam reg_idx_t REG_DATEVERSION = 10'd1;
    localparam reg_idx_t REG_CONTROL     = 10'd2;
    localparam reg_idx_t REG_SCRATCH     = 10'd3;
    localparam reg_idx_t REG_STATUS      = 10'd4;

    ////////////////////////////////////////
    // Identity constants
    ////////////////////////////////////////

    localparam wb_data_t   IDENT_WORD    = "TFIO";
    localparam logic [3:0] VER_MAJOR     = 4'd0;
    localparam logic [3:0] VER_MINOR     = 4'd3;
    localparam logic [7:0] VER_REV       = 8'd13;
    localparam logic [15:0] FIRMWARE_DATE = 16'h2c91;
    // Date on top, then major, minor, revision
    localparam wb_data_t   DATEVERSION   = {FIRMWARE_DATE, VER_MAJOR, VER_MINOR, VER_REV};

    // UART lines rest high
    localparam logic UART_IDLE = 1'b1;

    ////////////////////////////////////////
    // Bus and control bundles
    ////////////////////////////////////////

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // Control register, LSB is hskbus_local
    typedef struct packed {
        logic enable_3v3;
        logic enable_crate;
        logic cratebridge_en;
        logic hskbus_local;
    } ctrl_t;

endpackage

// ==== hdl/turfio_intercon.sv ====
module turfio_intercon (
    input  logic                init_clk,
    input  logic                rst_i,
    // From the bus master
    input  turfio_pkg::wb_req_t wb_req_i,
    output turfio_pkg::wb_rsp_t wb_rsp_o,
    // Toward the id/control block
    output turfio_pkg::wb_req_t idctrl_req_o,
    input  turfio_pkg::wb_rsp_t idctrl_rsp_i
);

    // Address seen as space/module/register
    turfio_pkg::wb_addr_fields_t adr_fields;
    // Space 0 and module 0
    logic                        idctrl_hit;
    // Default responder ack
    logic                        dflt_ack_q;
    logic                        dflt_start;
    turfio_pkg::wb_rsp_t         dflt_rsp;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign adr_fields = wb_req_i.adr;

    // Register field is left to the slave
    assign idctrl_hit = (adr_fields.space == turfio_pkg::SPACE_TURFIO) &&
                        (adr_fields.mod == turfio_pkg::MOD_ID_CTRL);

    // Whole request passes through
    // Strobe only reaches the block on a hit
    always_comb begin
        idctrl_req_o     = wb_req_i;
        idctrl_req_o.stb = wb_req_i.stb & idctrl_hit;
    end

    ////////////////////////////////////////
    // Default responder
    ////////////////////////////////////////

    // SURF space and every nonzero module land here
    // New strobe only, so the ack is a single pulse
    assign dflt_start = wb_req_i.cyc && wb_req_i.stb && !idctrl_hit && !dflt_ack_q;

    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            dflt_ack_q <= 1'b0;
        end else begin
            dflt_ack_q <= dflt_start;
        end
    end

    // Unmapped reads come back as zero
    always_comb begin
        dflt_rsp.ack = dflt_ack_q;
        dflt_rsp.dat = '0;
    end

    ////////////////////////////////////////
    // Response select
    ////////////////////////////////////////

    // Master holds adr until ack so the hit is still valid here
    always_comb begin
        if (idctrl_hit) begin
            wb_rsp_o = idctrl_rsp_i;
        end else begin
            wb_rsp_o = dflt_rsp;
        end
    end

endmodule

// ==== hdl/tio_id_ctrl.sv ====
module tio_id_ctrl (
    input  logic                init_clk,
    input  logic                rst_i,
    // Wishbone slave port
    input  turfio_pkg::wb_req_t wb_req_i,
    output turfio_pkg::wb_rsp_t wb_rsp_o,
    // Control bits to the router and crate enables
    output turfio_pkg::ctrl_t   ctrl_o,
    // Status inputs from the board
    input  logic                tctrl_b_i,
    input  logic [1:0]          conf_i
);

    localparam int CTRL_W = $bits(turfio_pkg::ctrl_t);
    localparam int STAT_W = 3;

    turfio_pkg::wb_addr_fields_t adr_fields;
    // Cycle not yet answered
    logic                        access;
    logic                        wr_en;
    logic                        ack_q;
    turfio_pkg::wb_data_t        rdat_q;
    turfio_pkg::wb_data_t        rdat_mux;
    // Register file
    turfio_pkg::ctrl_t           ctrl_q;
    turfio_pkg::wb_data_t        scratch_q;
    // Status sampling, conf above tctrl_b
    logic [STAT_W-1:0]           stat_meta_q;
    logic [STAT_W-1:0]           stat_sync_q;
    turfio_pkg::wb_data_t        status_word;

    assign adr_fields = wb_req_i.adr;

    // Strobe held through the ack cycle is not a new access
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en  = access && wb_req_i.we;

    ////////////////////////////////////////
    // Status inputs
    ////////////////////////////////////////

    // Two stages since these pins are asynchronous
    always_ff @(posedge init_clk) begin
        stat_meta_q <= {conf_i, tctrl_b_i};
        stat_sync_q <= stat_meta_q;
    end

    // Bit 0 tctrl_b, bits 2..1 conf
    assign status_word = {{($bits(turfio_pkg::wb_data_t) - STAT_W){1'b0}}, stat_sync_q};

    ////////////////////////////////////////
    // Writable registers
    ////////////////////////////////////////

    // Write lands on the edge that raises ack
    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            ctrl_q    <= '0;
            scratch_q <= '0;
        end else if (wr_en) begin
            case (adr_fields.idx)
                turfio_pkg::REG_CONTROL: begin
                    // Only the low bits exist
                    ctrl_q <= turfio_pkg::ctrl_t'(wb_req_i.dat[CTRL_W-1:0]);
                end
                turfio_pkg::REG_SCRATCH: begin
                    scratch_q <= wb_req_i.dat;
                end
                default: begin
                    // Read-only or unmapped, write dropped
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Readback and ack
    ////////////////////////////////////////

    always_comb begin
        rdat_mux = '0;
        case (adr_fields.idx)
            turfio_pkg::REG_IDENT:       rdat_mux = turfio_pkg::IDENT_WORD;
            turfio_pkg::REG_DATEVERSION: rdat_mux = turfio_pkg::DATEVERSION;
            turfio_pkg::REG_CONTROL:     rdat_mux[CTRL_W-1:0] = ctrl_q;
            turfio_pkg::REG_SCRATCH:     rdat_mux = scratch_q;
            turfio_pkg::REG_STATUS:      rdat_mux = status_word;
            default:                     rdat_mux = '0;
        endcase
    end

    // One-cycle ack pulse
    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Read word captured together with the ack
    always_ff @(posedge init_clk) begin
        if (access) begin
            rdat_q <= rdat_mux;
        end
    end

    always_comb begin
        wb_rsp_o.ack = ack_q;
        wb_rsp_o.dat = rdat_q;
    end

    assign ctrl_o = ctrl_q;

endmodule

// ==== hdl/uart_router.sv ====
module uart_router (
    input  logic              init_clk,
    input  logic              rst_i,
    // Routing controls
    input  turfio_pkg::ctrl_t ctrl_i,
    // Low selects the serial path from the trigger board
    input  logic              tctrl_b_i,
    // Debug UART
    input  logic              dbg_rx_i,
    output logic              dbg_tx_o,
    // Trigger-board UART
    input  logic              trx_i,
    output logic              ttx_o,
    // Crate housekeeping bus
    input  logic              crate_rx_i,
    output logic              crate_tx_o
);

    // Inputs that go through the retiming stages
    typedef struct packed {
        logic tctrl_b;
        logic crate_rx;
        logic trx;
        logic dbg_rx;
    } uart_in_t;

    uart_in_t raw;
    uart_in_t meta_q;
    uart_in_t sync_q;
    // Crate bus data after the bridge enable
    logic     crate_in;
    // Trigger-board source after the tctrl_b gate
    logic     turf_src;
    // What would go to the crate if enabled
    logic     crate_src;

    ////////////////////////////////////////
    // Input retiming
    ////////////////////////////////////////

    always_comb begin
        raw.tctrl_b  = tctrl_b_i;
        raw.crate_rx = crate_rx_i;
        raw.trx      = trx_i;
        raw.dbg_rx   = dbg_rx_i;
    end

    // Reset to idle so every output rests high
    always_ff @(posedge init_clk) begin
        if (rst_i) begin
            meta_q <= '1;
            sync_q <= '1;
        end else begin
            meta_q <= raw;
            sync_q <= meta_q;
        end
    end

    ////////////////////////////////////////
    // Routing
    ////////////////////////////////////////

    // Crate bus is deaf while the bridge is off
    assign crate_in = ctrl_i.cratebridge_en ? sync_q.crate_rx : turfio_pkg::UART_IDLE;

    // Trigger board only talks with tctrl_b low
    assign turf_src = sync_q.tctrl_b ? turfio_pkg::UART_IDLE : sync_q.trx;

    // Local mode hands the crate to the debug port
    assign crate_src = ctrl_i.hskbus_local ? sync_q.dbg_rx : turf_src;

    assign crate_tx_o = ctrl_i.cratebridge_en ? crate_src : turfio_pkg::UART_IDLE;

    // Debug port hears the crate in local mode
    // Otherwise its old partner is gone so it idles
    assign dbg_tx_o = ctrl_i.hskbus_local ? crate_in : turfio_pkg::UART_IDLE;

    // Trigger board hears the crate when not local
    assign ttx_o = ctrl_i.hskbus_local ? turfio_pkg::UART_IDLE : crate_in;

endmodule

// ==== hdl/turfio_core.sv ====
module turfio_core (
    input  logic                init_clk,
    input  logic                rst_i,
    // Wishbone slave port of the board
    input  turfio_pkg::wb_req_t wb_req_i,
    output turfio_pkg::wb_rsp_t wb_rsp_o,
    // Crate configuration straps
    input  logic [1:0]          conf_i,
    // Serial path select from the trigger board
    input  logic                tctrl_b_i,
    // Debug UART
    input  logic                dbg_rx_i,
    output logic                dbg_tx_o,
    // Trigger-board UART
    input  logic                trx_i,
    output logic                ttx_o,
    // SURF crate bus
    input  logic                crate_rx_i,
    output logic                crate_tx_o,
    // Crate supply enables
    output logic                enable_crate_o,
    output logic                enable_3v3_o
);

    // Decoded request into the id/control block
    turfio_pkg::wb_req_t idctrl_req;
    turfio_pkg::wb_rsp_t idctrl_rsp;
    // Control register contents
    turfio_pkg::ctrl_t   ctrl;

    ////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////

    turfio_intercon u_intercon (
        .init_clk     (init_clk),
        .rst_i        (rst_i),
        .wb_req_i     (wb_req_i),
        .wb_rsp_o     (wb_rsp_o),
        .idctrl_req_o (idctrl_req),
        .idctrl_rsp_i (idctrl_rsp)
    );

    ////////////////////////////////////////
    // Id and control registers
    ////////////////////////////////////////

    tio_id_ctrl u_id_ctrl (
        .init_clk  (init_clk),
        .rst_i     (rst_i),
        .wb_req_i  (idctrl_req),
        .wb_rsp_o  (idctrl_rsp),
        .ctrl_o    (ctrl),
        .tctrl_b_i (tctrl_b_i),
        .conf_i    (conf_i)
    );

    // Supply enables straight from the control bits
    assign enable_crate_o = ctrl.enable_crate;
    assign enable_3v3_o   = ctrl.enable_3v3;

    ////////////////////////////////////////
    // UART fabric
    ////////////////////////////////////////

    uart_router u_router (
        .init_clk   (init_clk),
        .rst_i      (rst_i),
        .ctrl_i     (ctrl),
        .tctrl_b_i  (tctrl_b_i),
        .dbg_rx_i   (dbg_rx_i),
        .dbg_tx_o   (dbg_tx_o),
        .trx_i      (trx_i),
        .ttx_o      (ttx_o),
        .crate_rx_i (crate_rx_i),
        .crate_tx_o (crate_tx_o)
    );

endmodule

// ==== bench/turfio_props.sv ====
module turfio_props (
    input logic                init_clk,
    input logic                rst_i,
    input turfio_pkg::wb_req_t wb_req_i,
    input turfio_pkg::wb_rsp_t wb_rsp_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Strobe of a cycle not answered yet
    logic req_open;
    // Number of assertion failures so far
    int   assert_fails = 0;

    assign req_open = wb_req_i.cyc && wb_req_i.stb && !wb_rsp_i.ack;

    // Ack only inside a live cycle
    ack_in_cycle: assert property (@(posedge init_clk) disable iff (rst_i)
        wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
        else begin
            $error("ack high without cyc and stb");
            assert_fails++;
        end

    // Single cycle pulse
    ack_single: assert property (@(posedge init_clk) disable iff (rst_i)
        $rose(wb_rsp_i.ack) |=> !wb_rsp_i.ack)
        else begin
            $error("ack held longer than one cycle");
            assert_fails++;
        end

    // Fixed latency of one cycle
    ack_latency: assert property (@(posedge init_clk) disable iff (rst_i)
        req_open |=> wb_rsp_i.ack)
        else begin
            $error("ack missing one cycle after a new strobe");
            assert_fails++;
        end

endmodule

bind turfio_intercon turfio_props u_props (
    .init_clk (init_clk),
    .rst_i    (rst_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_i (wb_rsp_o)
);

// ==== bench/turfio_checker.sv ====
module turfio_checker (
    input logic                 init_clk,
    input logic                 rst_i,
    input turfio_pkg::wb_req_t  wb_req_i,
    input turfio_pkg::wb_rsp_t  wb_rsp_i,
    // Read word the stimulus expects for the access in flight
    input turfio_pkg::wb_data_t exp_rdat_i,
    input logic                 tctrl_b_i,
    input logic                 dbg_rx_i,
    input logic                 trx_i,
    input logic                 crate_rx_i,
    input logic                 dbg_tx_i,
    input logic                 ttx_i,
    input logic                 crate_tx_i,
    input logic                 enable_crate_i,
    input logic                 enable_3v3_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // UART inputs as seen one edge apart
    typedef struct packed {
        logic tctrl_b;
        logic crate_rx;
        logic trx;
        logic dbg_rx;
    } uart_hist_t;

    int                err_count = 0;
    int                fail_count = 0;
    int                test_count = 0;
    int                test_err_base = 0;
    logic              armed = 1'b0;
    logic              exp_ack;
    logic              bus_hit;
    turfio_pkg::ctrl_t model_ctrl;
    uart_hist_t        h1;
    uart_hist_t        h2;
    logic              crate_in_exp;
    logic              crate_tx_exp;

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    // Called once a table row has run, enables must match its control column
    task automatic finish_test(input int idx, input logic [24:0] adr,
                               input turfio_pkg::ctrl_t ctrl);
        check_level("enable_crate_o", ctrl.enable_crate, enable_crate_i);
        check_level("enable_3v3_o", ctrl.enable_3v3, enable_3v3_i);
        test_count++;
        if (err_count == test_err_base) begin
            $display("test %0d adr %h: ok", idx, adr);
        end else begin
            fail_count++;
            $display("test %0d adr %h: %0d errors", idx, adr, err_count - test_err_base);
        end
        test_err_base = err_count;
    endtask

    task automatic print_totals();
        $display("%0d tests, %0d failed, %0d errors", test_count, fail_count, err_count);
    endtask

    ////////////////////////////////////////
    // Per-cycle model and compare
    ////////////////////////////////////////

    // Values read here belong to the cycle that just ended
    always @(posedge init_clk) begin
        if (armed) begin
            check_level("wb_rsp.ack", exp_ack, wb_rsp_i.ack);
            if (exp_ack && !wb_req_i.we) begin
                compare_word("wb_rsp.dat", exp_rdat_i, wb_rsp_i.dat);
            end
            check_level("enable_crate_o", model_ctrl.enable_crate, enable_crate_i);
            check_level("enable_3v3_o", model_ctrl.enable_3v3, enable_3v3_i);
            // Outputs lag the pins by two edges
            crate_in_exp = model_ctrl.cratebridge_en ? h2.crate_rx : 1'b1;
            if (!model_ctrl.cratebridge_en) begin
                crate_tx_exp = 1'b1;
            end else if (model_ctrl.hskbus_local) begin
                crate_tx_exp = h2.dbg_rx;
            end else begin
                crate_tx_exp = h2.tctrl_b ? 1'b1 : h2.trx;
            end
            check_level("crate_tx_o", crate_tx_exp, crate_tx_i);
            check_level("dbg_tx_o", model_ctrl.hskbus_local ? crate_in_exp : 1'b1, dbg_tx_i);
            check_level("ttx_o", model_ctrl.hskbus_local ? 1'b1 : crate_in_exp, ttx_i);
        end
        if (rst_i) begin
            armed      = 1'b1;
            exp_ack    = 1'b0;
            model_ctrl = '0;
            h1         = '1;
            h2         = '1;
        end else begin
            // Space 0 and module 0, control register 2
            bus_hit = (wb_req_i.adr[24:22] == 3'd0) && (wb_req_i.adr[21:10] == 12'd0);
            if (wb_req_i.cyc && wb_req_i.stb && !exp_ack && wb_req_i.we && bus_hit &&
                wb_req_i.adr[9:0] == 10'd2) begin
                model_ctrl = wb_req_i.dat[3:0];
            end
            exp_ack = wb_req_i.cyc && wb_req_i.stb && !exp_ack;
            h2      = h1;
            h1      = {tctrl_b_i, crate_rx_i, trx_i, dbg_rx_i};
        end
    end

endmodule

// ==== bench/tb_turfio.sv ====
module tb_turfio;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_STAT} op_e;

    // One row of the stimulus table
    typedef struct packed {
        op_e                  op;
        turfio_pkg::wb_addr_t adr;
        turfio_pkg::wb_data_t wdat;
        turfio_pkg::ctrl_t    ctrl;
        turfio_pkg::wb_data_t exp;
    } test_t;

    logic                 init_clk;
    logic                 rst_i;
    turfio_pkg::wb_req_t  wb_req;
    turfio_pkg::wb_rsp_t  wb_rsp;
    logic [1:0]           conf;
    logic                 tctrl_b;
    logic                 dbg_rx;
    logic                 dbg_tx;
    logic                 trx;
    logic                 ttx;
    logic                 crate_rx;
    logic                 crate_tx;
    logic                 enable_crate;
    logic                 enable_3v3;
    turfio_pkg::wb_data_t exp_rdat;
    test_t                tests[$];
    test_t                cur;
    logic [31:0]          rng;
    logic [31:0]          ident_word;
    logic [31:0]          dv_word;
    logic [31:0]          stat_word;
    int                   cycles;
    int                   cycle_limit;

    turfio_core DUT (
        .init_clk       (init_clk),
        .rst_i          (rst_i),
        .wb_req_i       (wb_req),
        .wb_rsp_o       (wb_rsp),
        .conf_i         (conf),
        .tctrl_b_i      (tctrl_b),
        .dbg_rx_i       (dbg_rx),
        .dbg_tx_o       (dbg_tx),
        .trx_i          (trx),
        .ttx_o          (ttx),
        .crate_rx_i     (crate_rx),
        .crate_tx_o     (crate_tx),
        .enable_crate_o (enable_crate),
        .enable_3v3_o   (enable_3v3)
    );

    turfio_checker u_checker (
        .init_clk       (init_clk),
        .rst_i          (rst_i),
        .wb_req_i       (wb_req),
        .wb_rsp_i       (wb_rsp),
        .exp_rdat_i     (exp_rdat),
        .tctrl_b_i      (tctrl_b),
        .dbg_rx_i       (dbg_rx),
        .trx_i          (trx),
        .crate_rx_i     (crate_rx),
        .dbg_tx_i       (dbg_tx),
        .ttx_i          (ttx),
        .crate_tx_i     (crate_tx),
        .enable_crate_i (enable_crate),
        .enable_3v3_i   (enable_3v3)
    );

    always #2 init_clk = ~init_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_test(input op_e op, input logic [2:0] space, input logic [11:0] mod,
                            input logic [9:0] idx, input logic [31:0] wdat,
                            input logic [3:0] ctrl, input logic [31:0] exp);
        test_t t;
        t.op   = op;
        t.adr  = {space, mod, idx};
        t.wdat = wdat;
        t.ctrl = ctrl;
        t.exp  = exp;
        tests.push_back(t);
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    task automatic load_table();
        // op, space, module, register, write data, control in force, read data
        add_test(OP_RD,   3'd0, 12'd0, 10'd0,   32'h0,         4'h0, ident_word);
        add_test(OP_RD,   3'd0, 12'd0, 10'd1,   32'h0,         4'h0, dv_word);
        add_test(OP_WR,   3'd0, 12'd0, 10'd0,   32'hffff_ffff, 4'h0, 32'h0);
        add_test(OP_RD,   3'd0, 12'd0, 10'd0,   32'h0,         4'h0, ident_word);
        add_test(OP_WR,   3'd0, 12'd0, 10'd3,   32'ha5c3_1e7f, 4'h0, 32'h0);
        add_test(OP_RD,   3'd0, 12'd0, 10'd3,   32'h0,         4'h0, 32'ha5c3_1e7f);
        add_test(OP_WR,   3'd0, 12'd0, 10'd2,   32'hffff_fff3, 4'h3, 32'h0);
        add_test(OP_RD,   3'd0, 12'd0, 10'd2,   32'h0,         4'h3, 32'h3);
        // SURF space, other modules and high registers answer with zero
        add_test(OP_RD,   3'd1, 12'd0, 10'd3,   32'h0,         4'h3, 32'h0);
        add_test(OP_WR,   3'd5, 12'd0, 10'd3,   32'hdead_beef, 4'h3, 32'h0);
        add_test(OP_RD,   3'd0, 12'd1, 10'd0,   32'h0,         4'h3, 32'h0);
        add_test(OP_WR,   3'd0, 12'd7, 10'd2,   32'h0000_000c, 4'h3, 32'h0);
        add_test(OP_RD,   3'd0, 12'd0, 10'd5,   32'h0,         4'h3, 32'h0);
        add_test(OP_WR,   3'd0, 12'd0, 10'h3ff, 32'h1234_5678, 4'h3, 32'h0);
        add_test(OP_RD,   3'd0, 12'd0, 10'd3,   32'h0,         4'h3, 32'ha5c3_1e7f);
        add_test(OP_RD,   3'd0, 12'd0, 10'd2,   32'h0,         4'h3, 32'h3);
        add_test(OP_STAT, 3'd0, 12'd0, 10'd4,   32'h0,         4'h3, 32'h0);
        // Bridge off, then trigger-board routing
        add_test(OP_WR,   3'd0, 12'd0, 10'd2,   32'h0000_000c, 4'hc, 32'h0);
        add_test(OP_STAT, 3'd0, 12'd0, 10'd4,   32'h0,         4'hc, 32'h0);
        add_test(OP_WR,   3'd0, 12'd0, 10'd2,   32'h0000_0006, 4'h6, 32'h0);
        add_test(OP_RD,   3'd0, 12'd0, 10'd2,   32'h0,         4'h6, 32'h6);
        add_test(OP_STAT, 3'd0, 12'd0, 10'd4,   32'h0,         4'h6, 32'h0);
        add_test(OP_WR,   3'd0, 12'd0, 10'd2,   32'h0000_000b, 4'hb, 32'h0);
        add_test(OP_RD,   3'd0, 12'd0, 10'd1,   32'h0,         4'hb, dv_word);
    endtask

    // Random UART bits, a new set every cycle
    task automatic stir_uarts(input int n);
        repeat (n) begin
            rng = xorshift32(rng);
            dbg_rx   <= rng[0];
            trx      <= rng[1];
            crate_rx <= rng[2];
            tctrl_b  <= rng[3];
            @(posedge init_clk);
        end
    endtask

    // Status pins held still long enough to pass the sync stages
    task automatic settle_status(output logic [31:0] word);
        rng = xorshift32(rng);
        tctrl_b <= rng[7];
        conf    <= rng[9:8];
        word = {29'd0, rng[9:8], rng[7]};
        repeat (4) @(posedge init_clk);
    endtask

    task automatic run_access(input test_t t);
        turfio_pkg::wb_req_t req;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = (t.op == OP_WR);
        req.adr = t.adr;
        req.dat = t.wdat;
        wb_req   <= req;
        exp_rdat <= t.exp;
        do begin
            @(posedge init_clk);
        end while (!wb_rsp.ack);
        // Drop the strobe after ack, then one idle cycle
        req.cyc = 1'b0;
        req.stb = 1'b0;
        req.we  = 1'b0;
        wb_req <= req;
        @(posedge init_clk);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        init_clk   = 1'b0;
        rst_i      = 1'b1;
        wb_req     = '0;
        exp_rdat   = '0;
        conf       = 2'b00;
        tctrl_b    = 1'b1;
        dbg_rx     = 1'b1;
        trx        = 1'b1;
        crate_rx   = 1'b1;
        rng        = 32'h5f61;
        cycles     = 0;
        // ASCII TFIO
        ident_word = 32'h5446_494f;
        dv_word    = {turfio_pkg::FIRMWARE_DATE, turfio_pkg::VER_MAJOR,
                      turfio_pkg::VER_MINOR, turfio_pkg::VER_REV};
        load_table();
        cycle_limit = 20 * tests.size() + 200;
        repeat (2) @(posedge init_clk);
        rst_i <= 1'b0;
        @(posedge init_clk);
        for (int i = 0; i < tests.size(); i++) begin
            cur = tests[i];
            if (cur.op == OP_STAT) begin
                settle_status(stat_word);
                cur.exp = stat_word;
            end
            run_access(cur);
            if (cur.op != OP_STAT) begin
                stir_uarts(8);
            end
            // Mid-cycle so the checker's edge compares are already done
            @(negedge init_clk);
            u_checker.finish_test(i, cur.adr, cur.ctrl);
            @(posedge init_clk);
        end
        // Compares of the last edge are complete by mid-cycle
        @(negedge init_clk);
        u_checker.print_totals();
        if (u_checker.err_count == 0 && DUT.u_intercon.u_props.assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog on the whole run
    always @(posedge init_clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the table did not finish", cycles);
            $display("Something failed");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
hdl/turfio_pkg.sv
hdl/turfio_intercon.sv
hdl/tio_id_ctrl.sv
hdl/uart_router.sv
hdl/turfio_core.sv
bench/turfio_props.sv
bench/turfio_checker.sv
bench/tb_turfio.sv
